/* uart_cfg_ctrl.f */
+incdir+.
uart_cfg_pkg.sv
rx_packet_decoder.sv
cfg_handshake_fsm.sv
uart_config_reg.sv
tx_packet_encoder.sv
uart_cfg_ctrl.sv
uart_cfg_ctrl_assertions.sv
uart_cfg_ctrl_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f uart_cfg_ctrl.f --top-module uart_cfg_ctrl_tb
	./obj_dir/Vuart_cfg_ctrl_tb | tee /dev/stderr | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

/* uart_cfg_ctrl_tb.sv */
// Peer model answers every request at once; timeouts are counted in cycles of the 100 ns clock

`timescale 1ns/1ps

`include "uart_cfg_macros.svh"

module uart_cfg_ctrl_tb;

  localparam uart_cfg_pkg::uart_cfg_t std_exp =
    '{data_width: uart_cfg_pkg::DW_8BIT, parity_mode: uart_cfg_pkg::NONE, stop_bits: 2'b00};

  logic clk_i = 1'b0;
  logic rst_n_i;
  uart_cfg_pkg::cpu_cmd_t cpu;
  uart_cfg_pkg::rx_side_t rx;
  logic peer_req;
  logic req_done;
  logic tx_done;
  logic tx_write_o;
  logic rx_read_o;
  logic line_req_o;
  logic stream_mode_o;
  logic cfg_done_o;
  uart_cfg_pkg::byte_t tx_data_o;
  uart_cfg_pkg::uart_cfg_t cfg_o;
  uart_cfg_pkg::uart_error_t error_o;

  int value_errs = 0;
  int timeout_errs = 0;
  logic [31:0] seed = 32'hfb6b;

  // Peer model state; the tasks only write ack_mode, slave_cnt, the push port and status bits
  logic ack_mode;
  uart_cfg_pkg::byte_t slave_pkts[4];
  int slave_cnt;
  int slave_idx;
  int req_rises;
  int tx_wait;
  // Configuration packets written to the TX FIFO during negotiations
  int field_writes;
  logic line_req_d;
  logic tx_field;
  logic push_en;
  logic st_par;
  logic st_fe;
  logic st_ov;
  uart_cfg_pkg::byte_t push_data;
  uart_cfg_pkg::byte_t rx_q[$];
  logic [31:0] peer_seed = 32'hfb6b;

  uart_cfg_ctrl dut0 (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .cpu_i(cpu), .rx_i(rx),
    .peer_req_i(peer_req), .req_done_i(req_done), .tx_done_i(tx_done),
    .tx_write_o(tx_write_o), .tx_data_o(tx_data_o), .rx_read_o(rx_read_o),
    .line_req_o(line_req_o), .stream_mode_o(stream_mode_o), .cfg_done_o(cfg_done_o),
    .cfg_o(cfg_o), .error_o(error_o)
  );

  bind uart_cfg_ctrl uart_cfg_ctrl_checker u_checker (
    .clk_i(clk_i), .rst_n_i(rst_n_i), .cpu_i(cpu_i), .rx_i(rx_i),
    .tx_write_o(tx_write_o), .tx_data_o(tx_data_o), .rx_read_o(rx_read_o),
    .line_req_o(line_req_o), .stream_mode_o(stream_mode_o), .cfg_done_o(cfg_done_o),
    .cfg_o(cfg_o), .error_o(error_o)
  );

  always #50 clk_i = ~clk_i;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  // --------------------------------------------------
  // Peer: line requester, transmitter and RX FIFO
  // --------------------------------------------------

  always @(posedge clk_i) begin
    if (!rst_n_i) begin
      rx_q.delete();
      req_done <= 1'b0;
      tx_done <= 1'b0;
      tx_wait <= 0;
      field_writes <= 0;
      line_req_d <= 1'b0;
      req_rises <= 0;
      slave_idx <= 0;
      rx <= '{data: 8'h00, empty: 1'b1, parity: 1'b0, frame_err: 1'b0, overrun_err: 1'b0};
    end else begin
      if (rx_read_o && rx_q.size() > 0) void'(rx_q.pop_front());
      if (push_en) rx_q.push_back(push_data);
      if (cfg_done_o) slave_idx <= 0;
      line_req_d <= line_req_o;
      if (line_req_o && !line_req_d) req_rises <= req_rises + 1;
      req_done <= line_req_o && !req_done;
      // Request finished, so the peer answers with its acknowledge
      if (line_req_o && req_done && ack_mode) rx_q.push_back(`UART_ACKN_BYTE);
      tx_done <= 1'b0;
      if (tx_write_o) begin
        tx_wait <= 1 + int'(peer_seed[17:16]);
        peer_seed <= lcg_next(peer_seed);
        tx_field <= (tx_data_o[7:4] == `UART_CFG_MARKER);
        // Field packets only go out while a negotiation is running
        if (stream_mode_o && tx_data_o[7:4] == `UART_CFG_MARKER) begin
          field_writes <= field_writes + 1;
        end
      end else if (tx_wait > 0) begin
        tx_wait <= tx_wait - 1;
        if (tx_wait == 1) begin
          tx_done <= 1'b1;
          if (ack_mode && tx_field) rx_q.push_back(`UART_ACKN_BYTE);
          // Slave side: every transmitted acknowledge draws the next packet
          if (slave_idx < slave_cnt) begin
            rx_q.push_back(slave_pkts[slave_idx]);
            slave_idx <= slave_idx + 1;
          end
        end
      end
      rx <= '{data: (rx_q.size() > 0) ? rx_q[0] : 8'h00, empty: (rx_q.size() == 0),
              parity: st_par, frame_err: st_fe, overrun_err: st_ov};
    end
  end

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------

  task automatic cpu_write_cfg(input uart_cfg_pkg::uart_cfg_t c);
    @(posedge clk_i);
    cpu.cfg <= c;
    cpu.cfg_wr <= 1'b1;
    @(posedge clk_i);
    cpu.cfg_wr <= 1'b0;
  endtask

  task automatic pulse_cfg_req();
    @(posedge clk_i);
    cpu.cfg_req <= 1'b1;
    @(posedge clk_i);
    cpu.cfg_req <= 1'b0;
  endtask

  task automatic pulse_peer_req();
    @(posedge clk_i);
    peer_req <= 1'b1;
    @(posedge clk_i);
    peer_req <= 1'b0;
  endtask

  task automatic pulse_irq_ack();
    @(posedge clk_i);
    cpu.irq_ack <= 1'b1;
    @(posedge clk_i);
    cpu.irq_ack <= 1'b0;
  endtask

  // Waits for the controller to leave idle and return, sampled on the falling edge
  task automatic wait_negotiation(input int limit, input string what);
    int n;
    n = 0;
    @(negedge clk_i);
    while (cfg_done_o && n < limit) begin
      @(negedge clk_i);
      n++;
    end
    while (!cfg_done_o && n < limit) begin
      @(negedge clk_i);
      n++;
    end
    if (n >= limit) begin
      timeout_errs++;
      $display("Timeout: %s did not finish within %0d cycles", what, limit);
    end
  endtask

  task automatic wait_rx_empty(input logic want, input string what);
    int n;
    n = 0;
    @(negedge clk_i);
    while (rx.empty != want && n < 100) begin
      @(negedge clk_i);
      n++;
    end
    if (n >= 100) begin
      timeout_errs++;
      $display("Timeout: RX FIFO never changed state during %s", what);
    end
  endtask

  task automatic check_result(input uart_cfg_pkg::uart_cfg_t exp, input logic err,
                              input string what);
    @(negedge clk_i);
    if (cfg_o !== exp || error_o.configuration !== err) begin
      value_errs++;
      $display("error %0t: %s cfg_o %h err %b, expected %h err %b", $time, what,
               cfg_o, error_o.configuration, exp, err);
    end
  endtask

  // Random bytes with random status bits under one parity mode
  task automatic idle_traffic(input uart_cfg_pkg::parity_mode_e pm, input int count);
    uart_cfg_pkg::uart_cfg_t c;
    seed = lcg_next(seed);
    c = '{data_width: uart_cfg_pkg::data_width_e'(seed[17:16]), parity_mode: pm,
          stop_bits: seed[19:18]};
    cpu_write_cfg(c);
    for (int i = 0; i < count; i++) begin
      seed = lcg_next(seed);
      @(posedge clk_i);
      push_data <= seed[23:16];
      push_en <= 1'b1;
      st_par <= seed[12];
      st_fe <= seed[13];
      st_ov <= seed[14];
      cpu.tx_write <= seed[15];
      cpu.tx_data <= seed[31:24];
      @(posedge clk_i);
      push_en <= 1'b0;
      cpu.tx_write <= 1'b0;
      wait_rx_empty(1'b0, "idle traffic");
      @(posedge clk_i);
      cpu.rx_read <= 1'b1;
      @(posedge clk_i);
      cpu.rx_read <= 1'b0;
      wait_rx_empty(1'b1, "idle traffic");
    end
    check_result(c, 1'b0, "idle traffic");
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------

  initial begin
    uart_cfg_pkg::uart_cfg_t c;
    int base;
    cpu = '0;
    rx = '{data: 8'h00, empty: 1'b1, parity: 1'b0, frame_err: 1'b0, overrun_err: 1'b0};
    rst_n_i = 1'b0;
    peer_req = 1'b0;
    req_done = 1'b0;
    tx_done = 1'b0;
    ack_mode = 1'b0;
    slave_cnt = 0;
    push_en = 1'b0;
    push_data = 8'h00;
    st_par = 1'b0;
    st_fe = 1'b0;
    st_ov = 1'b0;
    repeat (8) @(posedge clk_i);
    rst_n_i <= 1'b1;
    wait_negotiation(20, "reset");
    check_result(std_exp, 1'b0, "reset");

    // Master success with a random setup
    seed = lcg_next(seed);
    c = '{data_width: uart_cfg_pkg::data_width_e'(seed[17:16]),
          parity_mode: uart_cfg_pkg::parity_mode_e'(seed[19:18]), stop_bits: seed[21:20]};
    @(posedge clk_i);
    ack_mode <= 1'b1;
    cpu_write_cfg(c);
    base = field_writes;
    pulse_cfg_req();
    wait_negotiation(600, "master negotiation");
    // DW, PM, SB and EC each go out once
    if (field_writes - base != 4) begin
      value_errs++;
      $display("error %0t: %0d field packets sent, expected 4", $time, field_writes - base);
    end
    check_result(c, 1'b0, "master success");

    // Master failure, the peer stays silent
    @(posedge clk_i);
    ack_mode <= 1'b0;
    base = req_rises;
    pulse_cfg_req();
    wait_negotiation(1000, "master failure");
    if (req_rises - base != `UART_MAX_ATTEMPTS) begin
      value_errs++;
      $display("error %0t: %0d line requests, expected %0d", $time, req_rises - base,
               `UART_MAX_ATTEMPTS);
    end
    check_result(std_exp, 1'b1, "master failure");
    pulse_irq_ack();
    check_result(std_exp, 1'b0, "irq_ack after master failure");

    // Slave success with random options, EC carries option zero
    seed = lcg_next(seed);
    c = '{data_width: uart_cfg_pkg::data_width_e'(seed[17:16]),
          parity_mode: uart_cfg_pkg::parity_mode_e'(seed[19:18]), stop_bits: seed[21:20]};
    slave_pkts[0] = {`UART_CFG_MARKER, 2'd0, seed[17:16]};
    slave_pkts[1] = {`UART_CFG_MARKER, 2'd1, seed[19:18]};
    slave_pkts[2] = {`UART_CFG_MARKER, 2'd2, seed[21:20]};
    slave_pkts[3] = {`UART_CFG_MARKER, 2'd3, 2'd0};
    @(posedge clk_i);
    slave_cnt <= 4;
    pulse_peer_req();
    wait_negotiation(600, "slave negotiation");
    check_result(c, 1'b0, "slave success");

    // Slave timeout, nothing follows the first acknowledge
    @(posedge clk_i);
    slave_cnt <= 0;
    pulse_peer_req();
    wait_negotiation(600, "slave timeout");
    check_result(std_exp, 1'b1, "slave timeout");
    pulse_irq_ack();

    idle_traffic(uart_cfg_pkg::EVEN, 16);
    idle_traffic(uart_cfg_pkg::ODD, 16);

    $display("Errors: %0d value, %0d timeout, %0d assertion", value_errs, timeout_errs,
             dut0.u_checker.fail_count);
    if (value_errs == 0 && timeout_errs == 0 && dut0.u_checker.fail_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* uart_cfg_ctrl_assertions.sv */
// Checker for the configuration controller; it only watches ports and holds one failure count

`timescale 1ns/1ps

`include "uart_cfg_macros.svh"

module uart_cfg_ctrl_checker (
  input logic                     clk_i,
  input logic                     rst_n_i,
  input uart_cfg_pkg::cpu_cmd_t   cpu_i,
  input uart_cfg_pkg::rx_side_t   rx_i,
  input logic                     tx_write_o,
  input uart_cfg_pkg::byte_t      tx_data_o,
  input logic                     rx_read_o,
  input logic                     line_req_o,
  input logic                     stream_mode_o,
  input logic                     cfg_done_o,
  input uart_cfg_pkg::uart_cfg_t  cfg_o,
  input uart_cfg_pkg::uart_error_t error_o
);

  // Number of assertion failures so far, read by the testbench at the end
  int unsigned fail_count = 0;

  // Field that the master must announce next
  logic [1:0] exp_field;
  uart_cfg_pkg::cfg_opt_t exp_opt;
  logic field_write;
  logic parity_flag;

  // Expected parity error, built from the width and mode of the active setup
  function automatic logic parity_expect(uart_cfg_pkg::rx_side_t rx, uart_cfg_pkg::uart_cfg_t c);
    int   n;
    logic x;
    n = 5 + int'(c.data_width);
    x = 1'b0;
    for (int i = 0; i < 8; i++) begin
      if (i < n) x = x ^ rx.data[i];
    end
    x = x ^ (c.parity_mode == uart_cfg_pkg::ODD);
    return !rx.empty && (c.parity_mode[1] == 1'b0) && (rx.parity != x);
  endfunction

  assign field_write = tx_write_o && stream_mode_o && (tx_data_o[7:4] == `UART_CFG_MARKER);
  assign parity_flag = parity_expect(rx_i, cfg_o);

  always_comb begin
    case (exp_field)
      2'd0:    exp_opt = cfg_o.data_width;
      2'd1:    exp_opt = cfg_o.parity_mode;
      2'd2:    exp_opt = cfg_o.stop_bits;
      default: exp_opt = 2'b00;
    endcase
  end

  // A fresh line request always starts the field sequence over
  always_ff @(posedge clk_i) begin
    if (!rst_n_i || cfg_done_o || line_req_o) begin
      exp_field <= 2'd0;
    end else if (field_write) begin
      exp_field <= exp_field + 2'd1;
    end
  end

  // --------------------------------------------------
  // Properties
  // --------------------------------------------------

  reset_quiet: assert property (@(posedge clk_i)
    !rst_n_i |=> (!tx_write_o && !rx_read_o && !line_req_o && !stream_mode_o &&
                  !cfg_done_o && cfg_o == uart_cfg_pkg::cfg_std))
    else begin $error("outputs not quiet in or right after reset"); fail_count++; end

  reset_done: assert property (@(posedge clk_i) !rst_n_i ##1 rst_n_i |=> cfg_done_o)
    else begin $error("cfg_done_o did not rise after reset"); fail_count++; end

  // Outside the quiet cycle after reset, stream mode marks every cycle away from idle
  stream_flag: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(rst_n_i) |-> (stream_mode_o == !cfg_done_o))
    else begin $error("stream_mode_o does not mark the negotiation"); fail_count++; end

  idle_pass: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    cfg_done_o |-> (rx_read_o == cpu_i.rx_read && tx_write_o == cpu_i.tx_write &&
                    (!tx_write_o || tx_data_o == cpu_i.tx_data)))
    else begin $error("idle FIFO strobes or data differ from the CPU"); fail_count++; end

  error_bits: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    error_o.frame == rx_i.frame_err && error_o.overrun == rx_i.overrun_err &&
    error_o.parity == parity_flag)
    else begin $error("parity, frame or overrun error output is wrong"); fail_count++; end

  field_order: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    field_write |-> (tx_data_o[3:2] == exp_field && tx_data_o[1:0] == exp_opt))
    else begin $error("master field packet out of order or wrong option"); fail_count++; end

  slave_ackn: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    stream_mode_o && rx_read_o && !rx_i.empty && rx_i.data[7:4] == `UART_CFG_MARKER
    |=> tx_write_o && tx_data_o == `UART_ACKN_BYTE)
    else begin $error("slave packet was not acknowledged"); fail_count++; end

  fallback_std: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(error_o.configuration) |=> cfg_o == uart_cfg_pkg::cfg_std)
    else begin $error("standard setup not loaded after a failure"); fail_count++; end

  irq_clear: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    error_o.configuration && cpu_i.irq_ack |=> !error_o.configuration)
    else begin $error("irq_ack did not clear the configuration error"); fail_count++; end

endmodule

/* uart_cfg_ctrl.sv */
// Frame and overrun errors are passed through unqualified; the user must gate them with FIFO empty

`timescale 1ns/1ps

module uart_cfg_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_n_i,
  input  uart_cfg_pkg::cpu_cmd_t  cpu_i,
  input  uart_cfg_pkg::rx_side_t  rx_i,
  input  logic                    peer_req_i,
  input  logic                    req_done_i,
  input  logic                    tx_done_i,
  output logic                    tx_write_o,
  output uart_cfg_pkg::byte_t     tx_data_o,
  output logic                    rx_read_o,
  output logic                    line_req_o,
  output logic                    stream_mode_o,
  output logic                    cfg_done_o,
  output uart_cfg_pkg::uart_cfg_t cfg_o,
  output uart_cfg_pkg::uart_error_t error_o
);

  // --------------------------------------------------
  // Internal connections
  // --------------------------------------------------

  uart_cfg_pkg::rx_pkt_t     pkt;
  uart_cfg_pkg::tx_cmd_t     tx_cmd;
  uart_cfg_pkg::cfg_update_t upd;
  logic                      parity_err;
  logic                      cfg_err;
  logic                      idle;
  logic                      std_load;

  rx_packet_decoder u_decoder (
    .rx_i         (rx_i),
    .cfg_i        (cfg_o),
    .pkt_o        (pkt),
    .parity_err_o (parity_err)
  );

  cfg_handshake_fsm u_fsm (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .cpu_i         (cpu_i),
    .pkt_i         (pkt),
    .peer_req_i    (peer_req_i),
    .req_done_i    (req_done_i),
    .tx_done_i     (tx_done_i),
    .tx_cmd_o      (tx_cmd),
    .rx_read_o     (rx_read_o),
    .line_req_o    (line_req_o),
    .stream_mode_o (stream_mode_o),
    .idle_o        (idle),
    .std_load_o    (std_load),
    .upd_o         (upd),
    .cfg_err_o     (cfg_err)
  );

  uart_config_reg u_cfg_reg (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .cpu_i      (cpu_i),
    .idle_i     (idle),
    .std_load_i (std_load),
    .upd_i      (upd),
    .cfg_o      (cfg_o)
  );

  tx_packet_encoder u_encoder (
    .cmd_i      (tx_cmd),
    .cpu_i      (cpu_i),
    .cfg_i      (cfg_o),
    .tx_write_o (tx_write_o),
    .tx_data_o  (tx_data_o)
  );

  // --------------------------------------------------
  // Status
  // --------------------------------------------------

  // Configuration is settled whenever the controller sits in idle
  assign cfg_done_o = idle;

  assign error_o = '{
    configuration: cfg_err,
    parity:        parity_err,
    frame:         rx_i.frame_err,
    overrun:       rx_i.overrun_err
  };

endmodule

/* tx_packet_encoder.sv */
// Combinational; the byte is taken by the TX FIFO only in the cycle where the write strobe is high

`timescale 1ns/1ps

`include "uart_cfg_macros.svh"

module tx_packet_encoder (
  input  uart_cfg_pkg::tx_cmd_t   cmd_i,
  input  uart_cfg_pkg::cpu_cmd_t  cpu_i,
  input  uart_cfg_pkg::uart_cfg_t cfg_i,
  output logic                    tx_write_o,
  output uart_cfg_pkg::byte_t     tx_data_o
);

  // Current option of the field being announced
  uart_cfg_pkg::cfg_opt_t opt;

  always_comb begin
    tx_write_o = cmd_i.send;

    case (cmd_i.field)
      uart_cfg_pkg::DW: opt = cfg_i.data_width;
      uart_cfg_pkg::PM: opt = cfg_i.parity_mode;
      uart_cfg_pkg::SB: opt = cfg_i.stop_bits;
      // End of configuration always goes out with option zero
      default:          opt = 2'b00;
    endcase

    case (cmd_i.kind)
      uart_cfg_pkg::TX_ACKN:  tx_data_o = `UART_ACKN_BYTE;
      uart_cfg_pkg::TX_FIELD: tx_data_o = {`UART_CFG_MARKER, cmd_i.field, opt};
      default:                tx_data_o = cpu_i.tx_data;
    endcase
  end

endmodule

/* uart_config_reg.sv */
// CPU writes are ignored outside idle; a standard load overrides any field update in the same cycle

`timescale 1ns/1ps

module uart_config_reg (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  uart_cfg_pkg::cpu_cmd_t    cpu_i,
  input  logic                      idle_i,
  input  logic                      std_load_i,
  input  uart_cfg_pkg::cfg_update_t upd_i,
  output uart_cfg_pkg::uart_cfg_t   cfg_o
);

  uart_cfg_pkg::uart_cfg_t cfg_q;

  // --------------------------------------------------
  // Active line configuration
  // --------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      cfg_q <= uart_cfg_pkg::cfg_std;
    end else if (std_load_i) begin
      // Fallback after a failed negotiation or on CPU request
      cfg_q <= uart_cfg_pkg::cfg_std;
    end else if (upd_i.valid) begin
      // Slave path writes one field per received packet
      case (upd_i.field)
        uart_cfg_pkg::DW: begin
          cfg_q.data_width <= uart_cfg_pkg::data_width_e'(upd_i.option);
        end
        uart_cfg_pkg::PM: begin
          cfg_q.parity_mode <= uart_cfg_pkg::parity_mode_e'(upd_i.option);
        end
        uart_cfg_pkg::SB: begin
          cfg_q.stop_bits <= upd_i.option;
        end
        // End of configuration carries no setting
        default: begin
          cfg_q <= cfg_q;
        end
      endcase
    end else if (idle_i && cpu_i.cfg_wr) begin
      cfg_q <= cpu_i.cfg;
    end
  end

  assign cfg_o = cfg_q;

endmodule

/* cfg_handshake_fsm.sv */
// One write in flight at a time; stray RX bytes seen while a byte is awaited are popped and dropped

`timescale 1ns/1ps

`include "uart_cfg_macros.svh"

module cfg_handshake_fsm (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  uart_cfg_pkg::cpu_cmd_t    cpu_i,
  input  uart_cfg_pkg::rx_pkt_t     pkt_i,
  input  logic                      peer_req_i,
  input  logic                      req_done_i,
  input  logic                      tx_done_i,
  output uart_cfg_pkg::tx_cmd_t     tx_cmd_o,
  output logic                      rx_read_o,
  output logic                      line_req_o,
  output logic                      stream_mode_o,
  output logic                      idle_o,
  output logic                      std_load_o,
  output uart_cfg_pkg::cfg_update_t upd_o,
  output logic                      cfg_err_o
);

  localparam int timer_w   = $clog2(`UART_TIMEOUT_CYCLES);
  localparam int attempt_w = $clog2(`UART_MAX_ATTEMPTS + 1);

  uart_cfg_pkg::ctrl_state_e state_q;
  uart_cfg_pkg::ctrl_state_e state_d;

  // Cycles spent in the current state, cleared on every state change
  logic [timer_w-1:0] timer_q;
  logic [timer_w-1:0] timer_d;

  // Line requests already made in this negotiation, minus one
  logic [attempt_w-1:0] attempt_q;
  logic [attempt_w-1:0] attempt_d;

  // Master uses it as the field being sent, slave as the field last received
  uart_cfg_pkg::cfg_field_e field_q;
  uart_cfg_pkg::cfg_field_e field_d;

  logic timeout;
  logic last_attempt;
  logic set_err;
  logic cfg_err_q;

  assign timeout      = (timer_q == timer_w'(`UART_TIMEOUT_CYCLES - 1));
  assign last_attempt = (attempt_q == attempt_w'(`UART_MAX_ATTEMPTS - 1));
  assign timer_d      = (state_d != state_q) ? '0 : timer_q + 1'b1;

  // --------------------------------------------------
  // State and counter registers
  // --------------------------------------------------

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q   <= uart_cfg_pkg::RESET;
      timer_q   <= '0;
      attempt_q <= '0;
      field_q   <= uart_cfg_pkg::DW;
      cfg_err_q <= 1'b0;
    end else begin
      state_q   <= state_d;
      timer_q   <= timer_d;
      attempt_q <= attempt_d;
      field_q   <= field_d;
      // A new failure wins over an acknowledge in the same cycle
      if (set_err) begin
        cfg_err_q <= 1'b1;
      end else if (cpu_i.irq_ack) begin
        cfg_err_q <= 1'b0;
      end
    end
  end

  // --------------------------------------------------
  // Next state and strobes
  // --------------------------------------------------

  always_comb begin
    state_d    = state_q;
    attempt_d  = attempt_q;
    field_d    = field_q;
    set_err    = 1'b0;
    rx_read_o  = 1'b0;
    line_req_o = 1'b0;
    tx_cmd_o   = '{send: 1'b0, kind: uart_cfg_pkg::TX_CPU, field: field_q};
    upd_o      = '{valid: 1'b0, field: pkt_i.field, option: pkt_i.option};

    case (state_q)
      // One quiet cycle after reset before handing control to the CPU
      uart_cfg_pkg::RESET: begin
        state_d = uart_cfg_pkg::IDLE;
      end

      uart_cfg_pkg::IDLE: begin
        // CPU FIFO strobes go straight through while nothing is negotiated
        tx_cmd_o.send = cpu_i.tx_write;
        rx_read_o     = cpu_i.rx_read;
        attempt_d     = '0;
        field_d       = uart_cfg_pkg::DW;
        if (peer_req_i) begin
          state_d = uart_cfg_pkg::SLV_SEND_ACKN;
        end else if (cpu_i.cfg_req) begin
          state_d = uart_cfg_pkg::MST_REQ;
        end else if (cpu_i.std_cfg) begin
          state_d = uart_cfg_pkg::STD_LOAD;
        end
      end

      // Line request stays up until the requester reports it is done
      uart_cfg_pkg::MST_REQ: begin
        line_req_o = 1'b1;
        if (req_done_i) begin
          state_d = uart_cfg_pkg::MST_WAIT_REQ_ACKN;
        end
      end

      // Both master waits expect an acknowledge and retry the request on timeout
      uart_cfg_pkg::MST_WAIT_REQ_ACKN,
      uart_cfg_pkg::MST_WAIT_ACKN: begin
        rx_read_o = pkt_i.valid;
        if (pkt_i.is_ackn) begin
          if (state_q == uart_cfg_pkg::MST_WAIT_REQ_ACKN) begin
            state_d = uart_cfg_pkg::MST_SEND;
          end else if (field_q == uart_cfg_pkg::EC) begin
            state_d = uart_cfg_pkg::IDLE;
          end else begin
            field_d = uart_cfg_pkg::cfg_field_e'(field_q + 2'd1);
            state_d = uart_cfg_pkg::MST_SEND;
          end
        end else if (timeout) begin
          if (last_attempt) begin
            set_err = 1'b1;
            state_d = uart_cfg_pkg::STD_LOAD;
          end else begin
            // Start over from the first field on the next request
            attempt_d = attempt_q + 1'b1;
            field_d   = uart_cfg_pkg::DW;
            state_d   = uart_cfg_pkg::MST_REQ;
          end
        end
      end

      uart_cfg_pkg::MST_SEND: begin
        tx_cmd_o.send = 1'b1;
        tx_cmd_o.kind = uart_cfg_pkg::TX_FIELD;
        state_d       = uart_cfg_pkg::MST_WAIT_TX;
      end

      uart_cfg_pkg::SLV_SEND_ACKN: begin
        tx_cmd_o.send = 1'b1;
        tx_cmd_o.kind = uart_cfg_pkg::TX_ACKN;
        state_d       = uart_cfg_pkg::SLV_WAIT_TX;
      end

      // No further TX write until the transmitter has drained the last byte
      uart_cfg_pkg::MST_WAIT_TX,
      uart_cfg_pkg::SLV_WAIT_TX: begin
        if (tx_done_i) begin
          if (state_q == uart_cfg_pkg::MST_WAIT_TX) begin
            state_d = uart_cfg_pkg::MST_WAIT_ACKN;
          end else if (field_q == uart_cfg_pkg::EC) begin
            state_d = uart_cfg_pkg::IDLE;
          end else begin
            state_d = uart_cfg_pkg::SLV_WAIT_PKT;
          end
        end else if (timeout) begin
          set_err = 1'b1;
          state_d = uart_cfg_pkg::STD_LOAD;
        end
      end

      // Each configuration packet updates one field and is acknowledged
      uart_cfg_pkg::SLV_WAIT_PKT: begin
        rx_read_o = pkt_i.valid;
        if (pkt_i.is_cfg) begin
          upd_o.valid = 1'b1;
          field_d     = pkt_i.field;
          state_d     = uart_cfg_pkg::SLV_SEND_ACKN;
        end else if (timeout) begin
          set_err = 1'b1;
          state_d = uart_cfg_pkg::STD_LOAD;
        end
      end

      uart_cfg_pkg::STD_LOAD: begin
        state_d = uart_cfg_pkg::IDLE;
      end

      default: begin
        state_d = uart_cfg_pkg::IDLE;
      end
    endcase
  end

  // --------------------------------------------------
  // Status outputs
  // --------------------------------------------------

  assign idle_o        = (state_q == uart_cfg_pkg::IDLE);
  assign std_load_o    = (state_q == uart_cfg_pkg::STD_LOAD);
  // Reset cycle counts as quiet, every other non idle state is a negotiation
  assign stream_mode_o = !idle_o && (state_q != uart_cfg_pkg::RESET);
  assign cfg_err_o     = cfg_err_q;

endmodule

/* rx_packet_decoder.sv */
// Purely combinational; the head byte is only meaningful while the RX FIFO reports not empty

`timescale 1ns/1ps

`include "uart_cfg_macros.svh"

module rx_packet_decoder (
  input  uart_cfg_pkg::rx_side_t  rx_i,
  input  uart_cfg_pkg::uart_cfg_t cfg_i,
  output uart_cfg_pkg::rx_pkt_t   pkt_o,
  output logic                    parity_err_o
);

  // XOR over the data bits that the current width actually uses
  logic data_xor;
  // Set when the expected parity bit is the inverse of the data XOR
  logic odd_mode;
  // Set for EVEN and ODD, clear for both NONE codes
  logic check_en;

  // --------------------------------------------------
  // Packet classification
  // --------------------------------------------------

  always_comb begin
    pkt_o.valid   = !rx_i.empty;
    pkt_o.is_ackn = pkt_o.valid && (rx_i.data == `UART_ACKN_BYTE);
    pkt_o.is_cfg  = pkt_o.valid && (rx_i.data[7:4] == `UART_CFG_MARKER);
    // Field and option are split out whatever the byte is, is_cfg qualifies them
    pkt_o.field   = uart_cfg_pkg::cfg_field_e'(rx_i.data[3:2]);
    pkt_o.option  = rx_i.data[1:0];
  end

  // --------------------------------------------------
  // Parity check
  // --------------------------------------------------

  always_comb begin
    case (cfg_i.data_width)
      uart_cfg_pkg::DW_5BIT: data_xor = ^rx_i.data[4:0];
      uart_cfg_pkg::DW_6BIT: data_xor = ^rx_i.data[5:0];
      uart_cfg_pkg::DW_7BIT: data_xor = ^rx_i.data[6:0];
      default:               data_xor = ^rx_i.data;
    endcase
    odd_mode = (cfg_i.parity_mode == uart_cfg_pkg::ODD);
    check_en = (cfg_i.parity_mode == uart_cfg_pkg::EVEN) || odd_mode;
    // A mismatch only counts for a byte that is really present
    parity_err_o = pkt_o.valid && check_en && (rx_i.parity != (data_xor ^ odd_mode));
  end

endmodule

/* uart_cfg_pkg.sv */
// Field layouts are fixed; changing a struct changes the pin order of every port that carries it

package uart_cfg_pkg;

  // --------------------------------------------------
  // Plain vectors
  // --------------------------------------------------

  typedef logic [7:0] byte_t;
  typedef logic [1:0] cfg_opt_t;

  // --------------------------------------------------
  // Line configuration
  // --------------------------------------------------

  typedef enum logic [1:0] {
    DW_5BIT,
    DW_6BIT,
    DW_7BIT,
    DW_8BIT
  } data_width_e;

  // Both codes 2 and 3 disable the parity bit
  typedef enum logic [1:0] {
    EVEN,
    ODD,
    NONE,
    NONE_ALT
  } parity_mode_e;

  // Field identifier carried in bits 3 to 2 of a configuration packet
  typedef enum logic [1:0] {
    DW,
    PM,
    SB,
    EC
  } cfg_field_e;

  typedef struct packed {
    data_width_e  data_width;
    parity_mode_e parity_mode;
    cfg_opt_t     stop_bits;
  } uart_cfg_t;

  // Setup used after reset and whenever a negotiation fails
  localparam uart_cfg_t cfg_std = '{data_width: DW_8BIT, parity_mode: NONE, stop_bits: 2'b00};

  // --------------------------------------------------
  // Receive side
  // --------------------------------------------------

  // Head of the show-ahead RX FIFO plus the receiver status bits
  typedef struct packed {
    byte_t data;
    logic  empty;
    logic  parity;
    logic  frame_err;
    logic  overrun_err;
  } rx_side_t;

  // Classified RX head byte
  typedef struct packed {
    logic       valid;
    logic       is_ackn;
    logic       is_cfg;
    cfg_field_e field;
    cfg_opt_t   option;
  } rx_pkt_t;

  // --------------------------------------------------
  // CPU and transmit side
  // --------------------------------------------------

  typedef struct packed {
    logic      cfg_req;
    logic      std_cfg;
    logic      cfg_wr;
    uart_cfg_t cfg;
    logic      rx_read;
    logic      tx_write;
    byte_t     tx_data;
    logic      irq_ack;
  } cpu_cmd_t;

  // Source of the byte placed in the TX FIFO
  typedef enum logic [1:0] {
    TX_CPU,
    TX_ACKN,
    TX_FIELD
  } tx_kind_e;

  typedef struct packed {
    logic       send;
    tx_kind_e   kind;
    cfg_field_e field;
  } tx_cmd_t;

  // Single field write coming from the slave path
  typedef struct packed {
    logic       valid;
    cfg_field_e field;
    cfg_opt_t   option;
  } cfg_update_t;

  typedef struct packed {
    logic configuration;
    logic parity;
    logic frame;
    logic overrun;
  } uart_error_t;

  // --------------------------------------------------
  // Controller states
  // --------------------------------------------------

  typedef enum logic [3:0] {
    RESET,
    IDLE,
    MST_REQ,
    MST_WAIT_REQ_ACKN,
    MST_SEND,
    MST_WAIT_TX,
    MST_WAIT_ACKN,
    SLV_SEND_ACKN,
    SLV_WAIT_TX,
    SLV_WAIT_PKT,
    STD_LOAD
  } ctrl_state_e;

endpackage

/* uart_cfg_macros.svh */
// Timeout is counted in clock cycles, not in ms, so a 50 ms wait must be scaled to the clock by the user

`ifndef UART_CFG_MACROS_SVH
`define UART_CFG_MACROS_SVH

// --------------------------------------------------
// Negotiation timing
// --------------------------------------------------

// Longest time, in cycles, that any awaited acknowledge or packet may take
`define UART_TIMEOUT_CYCLES 64

// Line requests the master makes before it falls back to the standard setup
`define UART_MAX_ATTEMPTS 3

// --------------------------------------------------
// Packet encodings
// --------------------------------------------------

// Upper nibble that tags a byte as a configuration packet
`define UART_CFG_MARKER 4'b1010

// Byte sent back to confirm a request or a field packet
`define UART_ACKN_BYTE 8'hFF

`endif
